/* design/rv_pkg.sv */
package rv_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

  typedef logic [xlen-1:0]       word_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    op_lui    = 7'b011_0111,
    op_auipc  = 7'b001_0111,
    op_jal    = 7'b110_1111,
    op_jalr   = 7'b110_0111,
    op_branch = 7'b110_0011,
    op_load   = 7'b000_0011,
    op_store  = 7'b010_0011,
    op_imm    = 7'b001_0011,
    op_reg    = 7'b011_0011,
    op_system = 7'b111_0011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and
  } alu_op_e;

  typedef enum logic [1:0] {
    wb_alu,
    wb_mem,
    wb_link, // pc+4 for jal/jalr
    wb_imm   // lui
  } wb_sel_e;

  typedef struct packed {
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    word_t      imm;
    logic [2:0] funct3;
    alu_op_e    alu_op;
    logic       src_a_pc;  // operand a is pc, not rs1
    logic       src_b_imm; // operand b is imm, not rs2
    logic       reg_we;
    logic       mem_read;
    logic       mem_write;
    logic       is_branch;
    logic       is_jal;
    logic       is_jalr;
    wb_sel_e    wb_sel;
  } decoded_t;

  typedef struct packed {
    word_t      addr;  // word address, bits 1:0 cleared
    word_t      wdata; // already on its byte lanes
    logic [3:0] wmask;
    logic       re;
    logic       we;
  } dmem_req_t;

endpackage

/* design/rv_decoder.sv */
module rv_decoder (
  input  rv_pkg::word_t    inst,
  output rv_pkg::decoded_t dec
);

  rv_pkg::opcode_e opcode;
  rv_pkg::word_t   imm_i, imm_s, imm_b, imm_j, imm_u, imm_sh;
  rv_pkg::alu_op_e f3_op;
  logic [2:0]      funct3;
  logic            alt;      // funct7 bit 5

  assign opcode = rv_pkg::opcode_e'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign alt    = inst[30];

  // sign extended immediates
  assign imm_i  = {{20{inst[31]}}, inst[31:20]};
  assign imm_s  = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b  = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_j  = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
  assign imm_u  = {inst[31:12], 12'h000};
  assign imm_sh = {27'b0, inst[24:20]}; // slli/srli/srai shamt

  // funct3 to alu op, sub only for the register form
  always_comb begin
    case (funct3)
      3'b000:  f3_op = (alt && opcode == rv_pkg::op_reg) ? rv_pkg::alu_sub : rv_pkg::alu_add;
      3'b001:  f3_op = rv_pkg::alu_sll;
      3'b010:  f3_op = rv_pkg::alu_slt;
      3'b011:  f3_op = rv_pkg::alu_sltu;
      3'b100:  f3_op = rv_pkg::alu_xor;
      3'b101:  f3_op = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      3'b110:  f3_op = rv_pkg::alu_or;
      default: f3_op = rv_pkg::alu_and;
    endcase
  end

  always_comb begin
    dec        = '0;
    dec.rs1    = inst[19:15];
    dec.rs2    = inst[24:20];
    dec.rd     = inst[11:7];
    dec.funct3 = funct3;
    dec.alu_op = rv_pkg::alu_add;
    dec.wb_sel = rv_pkg::wb_alu;
    case (opcode)
      rv_pkg::op_lui: begin
        dec.imm    = imm_u;
        dec.reg_we = 1'b1;
        dec.wb_sel = rv_pkg::wb_imm;
      end
      rv_pkg::op_auipc: begin
        dec.imm       = imm_u;
        dec.src_a_pc  = 1'b1;
        dec.src_b_imm = 1'b1;
        dec.reg_we    = 1'b1;
      end
      rv_pkg::op_jal: begin
        dec.imm       = imm_j;
        dec.src_a_pc  = 1'b1;
        dec.src_b_imm = 1'b1;
        dec.reg_we    = 1'b1;
        dec.is_jal    = 1'b1;
        dec.wb_sel    = rv_pkg::wb_link;
      end
      rv_pkg::op_jalr: begin
        dec.imm       = imm_i;
        dec.src_b_imm = 1'b1;
        dec.reg_we    = 1'b1;
        dec.is_jalr   = 1'b1;
        dec.wb_sel    = rv_pkg::wb_link;
      end
      rv_pkg::op_branch: begin
        // alu forms the target, compare is done apart
        dec.imm       = imm_b;
        dec.src_a_pc  = 1'b1;
        dec.src_b_imm = 1'b1;
        dec.is_branch = 1'b1;
      end
      rv_pkg::op_load: begin
        dec.imm       = imm_i;
        dec.src_b_imm = 1'b1;
        dec.reg_we    = 1'b1;
        dec.mem_read  = 1'b1;
        dec.wb_sel    = rv_pkg::wb_mem;
      end
      rv_pkg::op_store: begin
        dec.imm       = imm_s;
        dec.src_b_imm = 1'b1;
        dec.mem_write = 1'b1;
      end
      rv_pkg::op_imm: begin
        dec.imm       = (funct3 == 3'b001 || funct3 == 3'b101) ? imm_sh : imm_i;
        dec.src_b_imm = 1'b1;
        dec.alu_op    = f3_op;
        dec.reg_we    = 1'b1;
      end
      rv_pkg::op_reg: begin
        dec.alu_op = f3_op;
        dec.reg_we = 1'b1;
      end
      rv_pkg::op_system: ; // no trap here, plain pc+4
      default: ;           // unknown opcode, nothing enabled
    endcase
  end

endmodule

/* design/rv_regfile.sv */
module rv_regfile (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              we,
  input  rv_pkg::reg_addr_t waddr,
  input  rv_pkg::word_t     wdata,
  input  rv_pkg::reg_addr_t raddr_a,
  input  rv_pkg::reg_addr_t raddr_b,
  output rv_pkg::word_t     rdata_a,
  output rv_pkg::word_t     rdata_b
);

  rv_pkg::word_t regs [1:31]; // x0 has no storage

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
  assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

/* design/rv_alu.sv */
module rv_alu (
  input  rv_pkg::decoded_t dec,
  input  rv_pkg::word_t    pc,
  input  rv_pkg::word_t    rs1_data,
  input  rv_pkg::word_t    rs2_data,
  output rv_pkg::word_t    result,
  output logic             branch_taken
);

  rv_pkg::word_t op_a, op_b;
  logic [4:0]    shamt;
  logic [32:0]   cmp_diff; // rs1 - rs2 with borrow on top
  logic          eq, lt, ltu;
  logic          cond;

  assign op_a  = dec.src_a_pc ? pc : rs1_data;
  assign op_b  = dec.src_b_imm ? dec.imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (dec.alu_op)
      rv_pkg::alu_add:  result = op_a + op_b;
      rv_pkg::alu_sub:  result = op_a - op_b;
      rv_pkg::alu_sll:  result = op_a << shamt;
      rv_pkg::alu_slt:  result = {31'b0, $signed(op_a) < $signed(op_b)};
      rv_pkg::alu_sltu: result = {31'b0, op_a < op_b};
      rv_pkg::alu_xor:  result = op_a ^ op_b;
      rv_pkg::alu_srl:  result = op_a >> shamt;
      rv_pkg::alu_sra:  result = $unsigned($signed(op_a) >>> shamt);
      rv_pkg::alu_or:   result = op_a | op_b;
      rv_pkg::alu_and:  result = op_a & op_b;
      default:          result = '0;
    endcase
  end

  // branch compare, own subtractor so the alu can form the target
  assign cmp_diff = {1'b0, rs1_data} - {1'b0, rs2_data};
  assign eq       = (cmp_diff[31:0] == '0);
  assign ltu      = cmp_diff[32];
  assign lt       = (rs1_data[31] ^ rs2_data[31]) ? rs1_data[31] : cmp_diff[31];

  always_comb begin
    case (dec.funct3)
      3'b000:  cond = eq;   // beq
      3'b001:  cond = !eq;  // bne
      3'b100:  cond = lt;   // blt
      3'b101:  cond = !lt;  // bge
      3'b110:  cond = ltu;  // bltu
      3'b111:  cond = !ltu; // bgeu
      default: cond = 1'b0;
    endcase
  end

  assign branch_taken = dec.is_branch & cond;

endmodule

/* design/rv_lsu.sv */
module rv_lsu (
  input  rv_pkg::decoded_t  dec,
  input  rv_pkg::word_t     addr,
  input  rv_pkg::word_t     rs2_data,
  input  rv_pkg::word_t     dmem_rdata,
  output rv_pkg::dmem_req_t dmem_req,
  output rv_pkg::word_t     load_data
);

  logic [1:0]    off;
  logic [4:0]    lane_shift;
  logic          aligned;
  logic [3:0]    size_mask;
  rv_pkg::word_t lane;

  assign off        = addr[1:0];
  assign lane_shift = {off, 3'b000};

  // funct3[1:0] gives the access size
  always_comb begin
    case (dec.funct3[1:0])
      2'b00: begin
        aligned   = 1'b1;
        size_mask = 4'b0001;
      end
      2'b01: begin
        aligned   = !off[0];
        size_mask = 4'b0011;
      end
      2'b10: begin
        aligned   = (off == 2'b00);
        size_mask = 4'b1111;
      end
      default: begin // no 64-bit access
        aligned   = 1'b0;
        size_mask = 4'b0000;
      end
    endcase
  end

  always_comb begin
    dmem_req.addr  = {addr[31:2], 2'b00};
    dmem_req.wdata = rs2_data << lane_shift;
    dmem_req.we    = dec.mem_write & aligned;
    dmem_req.re    = dec.mem_read & aligned;
    dmem_req.wmask = dmem_req.we ? (size_mask << off) : 4'b0000;
  end

  assign lane = dmem_rdata >> lane_shift; // selected lane now at bit 0

  always_comb begin
    load_data = '0;
    if (aligned) begin
      case (dec.funct3)
        3'b000:  load_data = {{24{lane[7]}}, lane[7:0]};   // lb
        3'b001:  load_data = {{16{lane[15]}}, lane[15:0]}; // lh
        3'b010:  load_data = lane;                         // lw
        3'b100:  load_data = {24'b0, lane[7:0]};           // lbu
        3'b101:  load_data = {16'b0, lane[15:0]};          // lhu
        default: load_data = '0;
      endcase
    end
  end

endmodule

/* design/rv_core_top.sv */
module rv_core_top (
  input  logic              clk,
  input  logic              arst_n,
  input  rv_pkg::word_t     inst,
  output rv_pkg::word_t     pc,
  output rv_pkg::dmem_req_t dmem_req,
  input  rv_pkg::word_t     dmem_rdata
);

  rv_pkg::decoded_t  dec;
  rv_pkg::word_t     rs1_data, rs2_data;
  rv_pkg::word_t     alu_result;
  logic              branch_taken;
  rv_pkg::word_t     load_data;
  rv_pkg::dmem_req_t lsu_req;
  rv_pkg::word_t     pc_plus4;
  rv_pkg::word_t     next_pc;
  rv_pkg::word_t     wb_data;

  assign pc_plus4 = pc + 32'd4;

  always_comb begin
    if (dec.is_jalr) begin
      next_pc = {alu_result[31:1], 1'b0}; // jalr drops bit 0
    end else if (dec.is_jal || branch_taken) begin
      next_pc = alu_result;
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= rv_pkg::reset_pc;
    end else begin
      pc <= next_pc;
    end
  end

  always_comb begin
    case (dec.wb_sel)
      rv_pkg::wb_alu:  wb_data = alu_result;
      rv_pkg::wb_mem:  wb_data = load_data;
      rv_pkg::wb_link: wb_data = pc_plus4;
      rv_pkg::wb_imm:  wb_data = dec.imm;
      default:         wb_data = alu_result;
    endcase
  end

  // no memory traffic while held in reset
  always_comb begin
    dmem_req    = lsu_req;
    dmem_req.re = lsu_req.re & arst_n;
    dmem_req.we = lsu_req.we & arst_n;
  end

  rv_decoder u_decoder (
    .inst (inst),
    .dec  (dec)
  );

  rv_regfile u_regfile (
    .clk     (clk),
    .arst_n  (arst_n),
    .we      (dec.reg_we),
    .waddr   (dec.rd),
    .wdata   (wb_data),
    .raddr_a (dec.rs1),
    .raddr_b (dec.rs2),
    .rdata_a (rs1_data),
    .rdata_b (rs2_data)
  );

  rv_alu u_alu (
    .dec          (dec),
    .pc           (pc),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .result       (alu_result),
    .branch_taken (branch_taken)
  );

  rv_lsu u_lsu (
    .dec        (dec),
    .addr       (alu_result),
    .rs2_data   (rs2_data),
    .dmem_rdata (dmem_rdata),
    .dmem_req   (lsu_req),
    .load_data  (load_data)
  );

endmodule

/* test/rv_core_sva.sv */
module rv_core_sva (
  input logic              clk,
  input logic              arst_n,
  input rv_pkg::word_t     pc,
  input rv_pkg::dmem_req_t dmem_req
);

  // one data access per cycle at most
  a_re_we_excl: assert property (@(posedge clk) disable iff (!arst_n)
    !(dmem_req.re && dmem_req.we))
    else $error("dmem_req has re and we high in the same cycle");

  a_wmask_set: assert property (@(posedge clk) disable iff (!arst_n)
    dmem_req.we |-> dmem_req.wmask != 4'b0000)
    else $error("dmem_req.we is high with an empty wmask");

  a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n)
    pc[1:0] == 2'b00)
    else $error("pc is not word aligned");

  // sampled before the first update after release
  a_reset_pc: assert property (@(posedge clk)
    $rose(arst_n) |-> pc == rv_pkg::reset_pc)
    else $error("pc differs from the reset pc in the first cycle after reset");

endmodule

bind rv_core_top rv_core_sva u_core_sva (
  .clk      (clk),
  .arst_n   (arst_n),
  .pc       (pc),
  .dmem_req (dmem_req)
);

/* test/tb_rv_core.sv */
module tb_rv_core;

  localparam int clk_period    = 20;
  localparam int reset_cycles  = 3;
  localparam int num_insts     = 2000;
  localparam int watchdog_time = (num_insts + 10) * clk_period + reset_cycles * clk_period;

  logic              clk;
  logic              arst_n;
  rv_pkg::word_t     inst;
  rv_pkg::word_t     pc;
  rv_pkg::dmem_req_t dmem_req;
  rv_pkg::word_t     dmem_rdata;

  logic [31:0] rng_state;
  logic [31:0] imem [logic [31:0]]; // filled on first fetch
  logic [31:0] dmem [logic [31:0]]; // keyed by word address
  logic [31:0] xr [32];             // model registers
  logic [31:0] mpc;
  logic        exp_we, exp_re;
  logic [31:0] exp_addr, exp_wdata;
  logic [3:0]  exp_mask;
  logic        pend_we;
  logic [31:0] pend_addr, pend_data;
  logic [3:0]  pend_mask;
  int          pc_errs, dmem_errs, reset_errs;

  rv_core_top UUT (
    .clk        (clk),
    .arst_n     (arst_n),
    .inst       (inst),
    .pc         (pc),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata)
  );

  always #(clk_period / 2) clk = ~clk;

  function automatic logic [31:0] xorshift32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // x0..x7 only, so results feed later instructions
  function automatic logic [4:0] pick_reg();
    logic [31:0] r;
    r = xorshift32();
    return {2'b00, r[2:0]};
  endfunction

  function automatic logic [31:0] random_inst();
    logic [31:0] r, s, ins;
    logic [4:0]  rd, rs1, rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    logic [12:0] boff;
    logic [20:0] joff;
    int          off;
    r   = xorshift32();
    s   = xorshift32();
    rd  = pick_reg();
    rs1 = pick_reg();
    rs2 = pick_reg();
    f3  = s[2:0];
    f7  = ((f3 == 3'd0 || f3 == 3'd5) && r[4]) ? 7'h20 : 7'h00; // sub, sra
    case (r % 5)
      0: begin
        if (r[3]) begin
          ins = {f7, rs2, rs1, f3, rd, 7'h33};
        end else begin
          case (f3)
            3'd1:    imm = {7'h00, s[8:4]};
            3'd5:    imm = {f7, s[8:4]};
            default: imm = s[19:8];
          endcase
          ins = {imm, rs1, f3, rd, 7'h13};
        end
      end
      1: ins = {s[31:12], rd, r[3] ? 7'h37 : 7'h17};
      2: begin
        if (r[3]) begin
          off = (int'(s[6:0]) - 64) * 4;
          if (off == 0) off = 8;
          joff = off[20:0];
          ins  = {joff[20], joff[10:1], joff[11], joff[19:12], rd, 7'h6f};
        end else begin
          // base x0 keeps the target aligned, imm bit 0 must be dropped
          ins = {s[11:2], 1'b0, s[0], 5'd0, 3'b000, rd, 7'h67};
        end
      end
      3: begin
        if (f3[2:1] == 2'b01) f3[2] = 1'b1; // no branch with funct3 2 or 3
        off = (int'(s[10:5]) - 32) * 4;
        if (off == 0) off = -8;
        boff = off[12:0];
        ins  = {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], 7'h63};
      end
      default: begin
        if (r[4]) rs1 = 5'd0; // small absolute addresses alias a lot
        imm = (rs1 == 5'd0) ? {6'b0, s[20:15]} : s[31:20];
        if (r[3]) begin
          if (f3 == 3'd3 || f3 >= 3'd6) f3 = 3'd2;
          ins = {imm, rs1, f3, rd, 7'h03};
        end else begin
          f3  = {1'b0, (s[1:0] == 2'b11) ? 2'b10 : s[1:0]};
          ins = {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
        end
      end
    endcase
    return ins;
  endfunction

  function automatic logic [31:0] fetch_inst(input logic [31:0] addr);
    if (!imem.exists(addr)) imem[addr] = random_inst();
    return imem[addr];
  endfunction

  // unwritten words hash the whole address
  function automatic logic [31:0] mem_word(input logic [31:0] waddr);
    if (dmem.exists(waddr)) return dmem[waddr];
    return (waddr ^ 32'h5a5a_c3c3) * 32'h9e37_79b1;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] nw,
                                              input logic [3:0] mask);
    for (int i = 0; i < 4; i++) begin
      if (mask[i]) old[i*8 +: 8] = nw[i*8 +: 8];
    end
    return old;
  endfunction

  function automatic logic access_ok(input logic [1:0] size, input logic [1:0] off);
    case (size)
      2'd0:    return 1'b1;
      2'd1:    return !off[0];
      2'd2:    return off == 2'd0;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_cond(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      3'd7:    return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // one retired instruction of the ISA model
  task automatic model_step(input logic [31:0] ins);
    logic [31:0] a, b, ea, res, nxt, w;
    logic [31:0] imm_i, imm_s, imm_b, imm_j;
    logic [2:0]  f3;
    logic [1:0]  off;
    logic        wr;
    a         = xr[ins[19:15]];
    b         = xr[ins[24:20]];
    f3        = ins[14:12];
    imm_i     = {{20{ins[31]}}, ins[31:20]};
    imm_s     = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b     = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j     = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    res       = '0;
    wr        = 1'b0;
    nxt       = mpc + 32'd4;
    exp_we    = 1'b0;
    exp_re    = 1'b0;
    exp_addr  = '0;
    exp_mask  = '0;
    exp_wdata = '0;
    case (ins[6:0])
      7'h37: begin
        res = {ins[31:12], 12'h000};
        wr  = 1'b1;
      end
      7'h17: begin
        res = mpc + {ins[31:12], 12'h000};
        wr  = 1'b1;
      end
      7'h6f: begin
        res = mpc + 32'd4;
        nxt = mpc + imm_j;
        wr  = 1'b1;
      end
      7'h67: begin
        res = mpc + 32'd4;
        nxt = (a + imm_i) & 32'hffff_fffe;
        wr  = 1'b1;
      end
      7'h63: if (branch_cond(f3, a, b)) nxt = mpc + imm_b;
      7'h03: begin
        ea       = a + imm_i;
        off      = ea[1:0];
        exp_re   = access_ok(f3[1:0], off); // misaligned load reads nothing
        exp_addr = {ea[31:2], 2'b00};
        w        = mem_word({ea[31:2], 2'b00}) >> {off, 3'b000};
        case (f3)
          3'd0:    res = {{24{w[7]}}, w[7:0]};
          3'd1:    res = {{16{w[15]}}, w[15:0]};
          3'd4:    res = {24'h0, w[7:0]};
          3'd5:    res = {16'h0, w[15:0]};
          default: res = w;
        endcase
        if (!access_ok(f3[1:0], off)) res = '0;
        wr = 1'b1;
      end
      7'h23: begin
        ea  = a + imm_s;
        off = ea[1:0];
        if (access_ok(f3[1:0], off)) begin
          exp_we    = 1'b1;
          exp_addr  = {ea[31:2], 2'b00};
          exp_mask  = ((f3 == 3'd0) ? 4'b0001 : (f3 == 3'd1) ? 4'b0011 : 4'b1111) << off;
          exp_wdata = b << {off, 3'b000};
        end
      end
      7'h13: begin
        res = alu_result(f3, ins[30] && f3 == 3'd5, a, imm_i);
        wr  = 1'b1;
      end
      7'h33: begin
        res = alu_result(f3, ins[30], a, b);
        wr  = 1'b1;
      end
      default: ; // system and unknown opcodes only advance pc
    endcase
    if (wr && ins[11:7] != 5'd0) xr[ins[11:7]] = res;
    mpc = nxt;
  endtask

  task automatic check_dmem_req();
    logic [31:0] lanes;
    lanes = {{8{exp_mask[3]}}, {8{exp_mask[2]}}, {8{exp_mask[1]}}, {8{exp_mask[0]}}};
    assert (dmem_req.we == exp_we) else begin
      dmem_errs++;
      $display("[ERROR] dmem_req.we: got %h expected %h at pc %h", dmem_req.we, exp_we, pc);
    end
    assert (dmem_req.re == exp_re) else begin
      dmem_errs++;
      $display("[ERROR] dmem_req.re: got %h expected %h at pc %h", dmem_req.re, exp_re, pc);
    end
    if (exp_we || exp_re) begin
      assert (dmem_req.addr == exp_addr) else begin
        dmem_errs++;
        $display("[ERROR] dmem_req.addr: got %h expected %h", dmem_req.addr, exp_addr);
      end
    end
    if (exp_we) begin
      assert (dmem_req.wmask == exp_mask) else begin
        dmem_errs++;
        $display("[ERROR] dmem_req.wmask: got %h expected %h", dmem_req.wmask, exp_mask);
      end
      // bytes outside the mask are don't care
      assert ((dmem_req.wdata & lanes) == (exp_wdata & lanes)) else begin
        dmem_errs++;
        $display("[ERROR] dmem_req.wdata: got %h expected %h mask %h",
                 dmem_req.wdata, exp_wdata, exp_mask);
      end
    end
  endtask

  task automatic check_reset_outputs(input string phase);
    assert (pc == rv_pkg::reset_pc) else begin
      reset_errs++;
      $display("[ERROR] pc: got %h expected %h %s", pc, rv_pkg::reset_pc, phase);
    end
    assert (!dmem_req.re && !dmem_req.we) else begin
      reset_errs++;
      $display("[ERROR] dmem_req re/we: got %h/%h expected 0/0 %s",
               dmem_req.re, dmem_req.we, phase);
    end
  endtask

  initial begin
    #(watchdog_time);
    $display("timeout: the run did not finish within %0d time units", watchdog_time);
    $display("Verification failed");
    $finish;
  end

  initial begin
    rng_state  = 32'd22343;
    clk        = 1'b0;
    arst_n     = 1'b0;
    inst       = 32'h0000_2023; // sw x0, 0(x0) while reset gates the strobes
    dmem_rdata = '0;
    mpc        = rv_pkg::reset_pc;
    pend_we    = 1'b0;
    pend_addr  = '0;
    pend_data  = '0;
    pend_mask  = '0;
    pc_errs    = 0;
    dmem_errs  = 0;
    reset_errs = 0;
    foreach (xr[i]) xr[i] = '0;
    repeat (reset_cycles - 1) @(posedge clk);
    #2;
    check_reset_outputs("during reset");
    inst = 32'h0000_2003; // lw x0, 0(x0)
    @(posedge clk);
    #2;
    check_reset_outputs("during reset");
    inst   = 32'h0000_0013; // nop
    arst_n = 1'b1;
    #2;
    check_reset_outputs("after reset");
    model_step(inst); // the nop cycle right after release
    for (int n = 0; n < num_insts; n++) begin
      @(posedge clk);
      if (pend_we) dmem[pend_addr] = merge_bytes(mem_word(pend_addr), pend_data, pend_mask);
      #2;
      assert (pc == mpc) else begin
        pc_errs++;
        $display("[ERROR] pc: got %h expected %h", pc, mpc);
      end
      inst = fetch_inst(pc);
      #2;
      dmem_rdata = mem_word(dmem_req.addr);
      #6;
      model_step(inst);
      check_dmem_req();
      pend_we   = dmem_req.we;
      pend_addr = dmem_req.addr;
      pend_data = dmem_req.wdata;
      pend_mask = dmem_req.wmask;
    end
    $display("errors: pc %0d, dmem %0d, reset %0d", pc_errs, dmem_errs, reset_errs);
    if (pc_errs + dmem_errs + reset_errs == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* compile.f */
design/rv_pkg.sv
design/rv_decoder.sv
design/rv_regfile.sv
design/rv_alu.sv
design/rv_lsu.sv
design/rv_core_top.sv
test/rv_core_sva.sv
test/tb_rv_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= -j 0
PASS_MSG  ?= Verification passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) --binary --timing --assert $(VFLAGS) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
